// ==== filelist.f ====
verilog/cordic_pkg.sv
verilog/atan_rom.sv
verilog/cordic_counters.sv
verilog/cordic_fsm.sv
verilog/cordic_xyz_regs.sv
verilog/exp_shift_stage.sv
verilog/quadrant_fixup.sv
verilog/cordic_sincos.sv
test/cordic_checker.sv
test/tb_cordic.sv

// ==== Bender.yml ====
package:
  name: cordic_sincos

sources:
  - files:
      - verilog/cordic_pkg.sv
      - verilog/atan_rom.sv
      - verilog/cordic_counters.sv
      - verilog/cordic_fsm.sv
      - verilog/cordic_xyz_regs.sv
      - verilog/exp_shift_stage.sv
      - verilog/quadrant_fixup.sv
      - verilog/cordic_sincos.sv
  - target: test
    files:
      - test/cordic_checker.sv
      - test/tb_cordic.sv

// ==== test/tb_cordic.sv ====
// CORDIC sine/cosine testbench with float adder model, reference model and result compare
`default_nettype none

module tb_cordic import cordic_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int   N_RAND       = 8;                          // Ops per random group
    localparam int   N_OPS        = 4 * N_RAND;                 // Cos, sin, quadrant, back-to-back
    localparam int   LIMIT_CYCLES = N_OPS * 16 * 3 * 8 + 1000;  // Worst case plus margin
    localparam float_t FIXED_ANGLE = 32'h3f000000;              // 0.5 rad

    logic   clk;
    logic   rst;
    logic   beg_fsm_cordic;
    logic   ack_cordic;
    logic   operation;
    float_t data_in;
    logic [1:0] shift_region_flag;
    logic   ready_cordic;
    float_t data_output;
    logic   beg_add_subt;
    float_t add_subt_data_a;
    float_t add_subt_data_b;
    logic   op_add_subt;
    float_t result_add_subt;
    logic   ready_add_subt;

    float_t      exp_q[$];                  // Expected results in issue order
    int          results_checked = 0;
    logic [31:0] lcg_state = 32'd96;        // Shared random state

    cordic_sincos #(.ITER_BITS(ITER_BITS)) u_cordic_sincos (.*);

    // ==============================
    // Helpers
    // ==============================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic float_t fp_add(input float_t a, input float_t b, input logic sub);
        shortreal ra, rb, rs;
        ra = $bitstoshortreal(a);
        rb = $bitstoshortreal(b);
        rs = sub ? ra - rb : ra + rb;       // 1 = A minus B
        return $shortrealtobits(rs);
    endfunction

    function automatic float_t random_angle();
        real      frac;
        shortreal s;
        frac = real'(lcg_next() >> 8) / 16777216.0;
        s = -0.78 + 2.35 * frac;            // Span -0.78 to 1.57
        return $shortrealtobits(s);
    endfunction

    // atan(2^-k) as single-precision bits
    function automatic float_t atan_const(input int k);
        case (k)
            0:  return 32'h3f490fdb;
            1:  return 32'h3eed6338;
            2:  return 32'h3e7adbb0;
            3:  return 32'h3dfeadd5;
            4:  return 32'h3d7faade;
            5:  return 32'h3cffeaae;
            6:  return 32'h3c7ffaab;
            7:  return 32'h3bfffeab;
            8:  return 32'h3b7fffab;
            9:  return 32'h3affffeb;
            10: return 32'h3a7ffffb;
            11: return 32'h39ffffff;
            12: return 32'h39800000;
            13: return 32'h39000000;
            14: return 32'h38800000;
            default: return 32'h38000000;
        endcase
    endfunction

    // Multiply by 2^-n and flush to zero on exponent underflow
    function automatic float_t scale_by_pow2(input float_t v, input iter_t n);
        logic [EXP_W-1:0] e;
        e = v[DATA_W-2:MAN_W];
        if (e <= EXP_W'(n))
            return '0;
        return {v[DATA_W-1], e - EXP_W'(n), v[MAN_W-1:0]};
    endfunction

    function automatic float_t cordic_ref(input float_t angle, input logic op,
                                          input logic [1:0] region);
        float_t x, y, z, x_next, y_next, r;
        logic   d_neg;
        int     k;
        x = X_INIT;
        y = '0;
        z = angle;
        for (k = 0; k < 2 ** ITER_BITS; k++)
        begin
            d_neg  = z[DATA_W-1];           // Rotate toward zero angle
            x_next = fp_add(x, scale_by_pow2(y, iter_t'(k)), !d_neg);
            y_next = fp_add(y, scale_by_pow2(x, iter_t'(k)), d_neg);
            z      = fp_add(z, atan_const(k), !d_neg);
            x      = x_next;
            y      = y_next;
        end
        case ({op, region})
            3'b0_00: r = x;
            3'b0_01: r = {~y[DATA_W-1], y[DATA_W-2:0]};
            3'b0_10: r = {~x[DATA_W-1], x[DATA_W-2:0]};
            3'b0_11: r = y;
            3'b1_00: r = y;
            3'b1_01: r = x;
            3'b1_10: r = {~y[DATA_W-1], y[DATA_W-2:0]};
            default: r = {~x[DATA_W-1], x[DATA_W-2:0]};
        endcase
        return r;
    endfunction

    task automatic check_float(input float_t got, input float_t exp, input string what);
        if (got !== exp)
        begin
            $display("Fail at %0d ns: %s got %h expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "Float mismatch");
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("Fail at %0d ns: %s got %b expected %b", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "Level mismatch");
        end
    endtask

    // One operation entered and left on a rising edge
    task automatic run_op(input float_t angle, input logic op, input logic [1:0] region,
                          input int gap);
        int ack_wait;
        repeat (gap) @(posedge clk);
        exp_q.push_back(cordic_ref(angle, op, region));
        beg_fsm_cordic    <= 1'b1;
        data_in           <= angle;
        operation         <= op;
        shift_region_flag <= region;
        @(posedge clk);
        beg_fsm_cordic <= 1'b0;
        while (!ready_cordic)
            @(posedge clk);
        ack_wait = int'(lcg_next() >> 16) % 11;     // Hold 0 to 10 cycles
        repeat (ack_wait) @(posedge clk);
        ack_cordic <= 1'b1;
        @(posedge clk);
        ack_cordic <= 1'b0;
    endtask

    // ==============================
    // Clock and watchdog
    // ==============================
    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;             // 100 ns period
    end

    initial
    begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("Watchdog expired at %0d ns because the DUT stopped making progress", $time);
        $display("Simulation failed");
        $fatal(1, "Timeout");
    end

    // Bound interface assertions
    initial
    begin : assertion_watch
        wait (u_cordic_sincos.u_checker.err_count != 0);
        $display("An interface assertion on the DUT failed at %0d ns", $time);
        $display("Simulation failed");
        $fatal(1, "Assertion failure");
    end

    // Adder model with 1 to 4 cycles per request
    initial
    begin : adder_model
        float_t op_a, op_b;
        logic   op_s;
        int     lat;
        ready_add_subt  = 1'b0;
        result_add_subt = '0;
        forever
        begin
            @(posedge clk);
            if (!rst && beg_add_subt)
            begin
                op_a = add_subt_data_a;
                op_b = add_subt_data_b;
                op_s = op_add_subt;
                lat  = 1 + int'(lcg_next() >> 16) % 4;
                repeat (lat - 1) @(posedge clk);
                ready_add_subt  <= 1'b1;
                result_add_subt <= fp_add(op_a, op_b, op_s);
                @(posedge clk);
                ready_add_subt  <= 1'b0;
            end
        end
    end

    // ==============================
    // Compare process
    // ==============================
    initial
    begin : compare_results
        float_t held;
        float_t exp_val;
        logic   prev_ready;
        logic   prev_ack;
        held       = '0;
        prev_ready = 1'b0;
        prev_ack   = 1'b0;
        forever
        begin
            @(posedge clk);
            if (!rst)
            begin
                if (prev_ready && !prev_ack)            // Still holding
                begin
                    check_level(ready_cordic, 1'b1, "ready_cordic before ack");
                    check_float(data_output, held, "data_output while held");
                end
                if (ready_cordic && !prev_ready)
                begin
                    if (exp_q.size() == 0)
                    begin
                        $display("ready_cordic rose with no operation outstanding");
                        $display("Simulation failed");
                        $fatal(1, "Unexpected result");
                    end
                    else
                    begin
                        exp_val = exp_q.pop_front();
                        check_float(data_output, exp_val, "result");
                        held = exp_val;
                        results_checked++;
                    end
                end
                prev_ready = ready_cordic;
                prev_ack   = ack_cordic;
            end
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    initial
    begin : stimulus
        int          k;
        logic [31:0] r;
        rst               = 1'b1;
        beg_fsm_cordic    = 1'b0;
        ack_cordic        = 1'b0;
        operation         = 1'b0;
        data_in           = '0;
        shift_region_flag = 2'b00;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_level(ready_cordic, 1'b0, "ready_cordic after reset");
        check_level(beg_add_subt, 1'b0, "beg_add_subt after reset");
        check_float(data_output, '0, "data_output after reset");

        for (k = 0; k < N_RAND; k++)
            run_op(random_angle(), 1'b0, 2'd0, 2);      // Cosine
        for (k = 0; k < N_RAND; k++)
            run_op(random_angle(), 1'b1, 2'd0, 2);      // Sine
        for (k = 0; k < 8; k++)
            run_op(FIXED_ANGLE, k[2], k[1:0], 1);       // All quadrant flags
        for (k = 0; k < N_RAND; k++)
        begin
            r = lcg_next();
            run_op(random_angle(), r[31], r[30:29], 0); // Back-to-back
        end

        repeat (2) @(posedge clk);
        if (results_checked == N_OPS && exp_q.size() == 0)
        begin
            $display("Simulation passed");
            $finish;
        end
        else
        begin
            $display("Only %0d of %0d results were seen", results_checked, N_OPS);
            $display("Simulation failed");
            $fatal(1, "Missing results");
        end
    end

endmodule : tb_cordic

`default_nettype wire

// ==== test/cordic_checker.sv ====
// CORDIC interface checker for adder strobes and result hold in the top level
`default_nettype none

module cordic_checker import cordic_pkg::*;
(
    input wire logic   clk,
    input wire logic   rst,
    input wire logic   beg_add_subt,
    input wire logic   ready_add_subt,
    input wire float_t add_subt_data_a,
    input wire float_t add_subt_data_b,
    input wire logic   op_add_subt,
    input wire logic   ready_cordic,
    input wire logic   ack_cordic,
    input wire float_t data_output
);
    timeunit 1ns;
    timeprecision 1ps;

    logic add_pending;                      // Request issued and not yet answered
    int   err_count = 0;                    // Failed assertions so far

    always_ff @(posedge clk)
    begin
        if (rst)
            add_pending <= 1'b0;
        else if (beg_add_subt)
            add_pending <= 1'b1;
        else if (ready_add_subt)
            add_pending <= 1'b0;
    end

    // ==============================
    // Adder handshake
    // ==============================
    a_single_beg: assert property (@(posedge clk) disable iff (rst)
        add_pending |-> !beg_add_subt)
    else
    begin
        $error("Second beg_add_subt before ready_add_subt");
        err_count++;
    end

    a_operands_stable: assert property (@(posedge clk) disable iff (rst)
        add_pending |-> ($stable(add_subt_data_a) && $stable(add_subt_data_b)
                         && $stable(op_add_subt)))
    else
    begin
        $error("Adder operands changed while waiting");
        err_count++;
    end

    // Result hold
    a_ready_hold: assert property (@(posedge clk) disable iff (rst)
        (ready_cordic && !ack_cordic) |=> ready_cordic)
    else
    begin
        $error("ready_cordic dropped before ack_cordic");
        err_count++;
    end

    a_output_hold: assert property (@(posedge clk) disable iff (rst)
        (ready_cordic && !ack_cordic) |=> $stable(data_output))
    else
    begin
        $error("data_output changed before ack_cordic");
        err_count++;
    end

endmodule : cordic_checker

bind cordic_sincos cordic_checker u_checker (.*);

`default_nettype wire

// ==== verilog/cordic_sincos.sv ====
// CORDIC sine/cosine unit in rotation mode driving an external float adder
`default_nettype none

module cordic_sincos import cordic_pkg::*;
#(
    parameter int ITER_BITS = cordic_pkg::ITER_BITS    // Iteration counter width
)
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   beg_fsm_cordic,     // Start pulse
    input  wire logic   ack_cordic,         // Result taken
    input  wire logic   operation,          // 1 sine, 0 cosine
    input  wire float_t data_in,            // Angle in radians
    input  wire logic [1:0] shift_region_flag,
    output logic        ready_cordic,
    output float_t      data_output,
    // Adder strobes
    output logic        beg_add_subt,
    output float_t      add_subt_data_a,
    output float_t      add_subt_data_b,
    output logic        op_add_subt,        // 1 = A minus B
    input  wire float_t result_add_subt,
    input  wire logic   ready_add_subt
);

    logic   enab_rb1, enab_rb2, enab_rb3;   // Register bank loads
    logic   enab_cont_iter, clear_counters, enab_out;
    logic   max_tick_iter, max_tick_var, first_iter;
    iter_t  iter_count;
    var_t   var_count;
    float_t atan_value;                     // ROM output
    float_t x_cur, y_cur, z_cur;            // Operands of this iteration
    float_t x_new, y_new;                   // Adder write-back
    logic   operation_q;
    logic [1:0] region_q;

    cordic_fsm u_fsm (
        .clk(clk), .rst(rst), .beg_fsm_cordic(beg_fsm_cordic), .ack_cordic(ack_cordic),
        .ready_add_subt(ready_add_subt), .max_tick_iter(max_tick_iter),
        .max_tick_var(max_tick_var), .ready_cordic(ready_cordic),
        .beg_add_subt(beg_add_subt), .enab_rb1(enab_rb1), .enab_rb2(enab_rb2),
        .enab_rb3(enab_rb3), .enab_cont_iter(enab_cont_iter),
        .clear_counters(clear_counters), .enab_out(enab_out)
    );

    cordic_counters #(.ITER_BITS(ITER_BITS)) u_counters (
        .clk(clk), .rst(rst), .clear_counters(clear_counters),
        .enab_cont_iter(enab_cont_iter), .ready_add_subt(ready_add_subt),
        .iter_count(iter_count), .var_count(var_count), .first_iter(first_iter),
        .max_tick_iter(max_tick_iter), .max_tick_var(max_tick_var)
    );

    atan_rom #(.ITER_BITS(ITER_BITS)) u_atan_rom (
        .iter_count(iter_count), .atan_value(atan_value)
    );

    cordic_xyz_regs u_xyz_regs (
        .clk(clk), .rst(rst), .enab_rb1(enab_rb1), .enab_rb2(enab_rb2),
        .first_iter(first_iter), .var_count(var_count), .ready_add_subt(ready_add_subt),
        .data_in(data_in), .result_add_subt(result_add_subt), .operation(operation),
        .shift_region_flag(shift_region_flag), .x_cur(x_cur), .y_cur(y_cur),
        .z_cur(z_cur), .operation_q(operation_q), .region_q(region_q),
        .x_new(x_new), .y_new(y_new)
    );

    exp_shift_stage #(.ITER_BITS(ITER_BITS)) u_shift (
        .clk(clk), .rst(rst), .enab_rb3(enab_rb3), .iter_count(iter_count),
        .var_count(var_count), .x_cur(x_cur), .y_cur(y_cur), .z_cur(z_cur),
        .atan_value(atan_value), .add_subt_data_a(add_subt_data_a),
        .add_subt_data_b(add_subt_data_b), .op_add_subt(op_add_subt)
    );

    quadrant_fixup u_fixup (
        .clk(clk), .rst(rst), .enab_out(enab_out), .x_new(x_new), .y_new(y_new),
        .operation_q(operation_q), .region_q(region_q), .data_output(data_output)
    );

endmodule : cordic_sincos

`default_nettype wire

// ==== verilog/quadrant_fixup.sv ====
// CORDIC result select and quadrant sign correction with output register
`default_nettype none

module quadrant_fixup import cordic_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   enab_out,           // Final iteration done
    input  wire float_t x_new,              // Cosine of reduced angle
    input  wire float_t y_new,              // Sine of reduced angle
    input  wire logic   operation_q,        // 1 sine, 0 cosine
    input  wire logic [1:0] region_q,       // Quadrant
    output float_t      data_output
);

    logic   sel_y;                          // Take Y instead of X
    logic   negate;                         // Flip sign bit
    float_t mux_sal;

    always_comb
    begin
        case ({operation_q, region_q})
            3'b0_00: {sel_y, negate} = 2'b00;   // cos  X
            3'b0_01: {sel_y, negate} = 2'b11;   // cos -Y
            3'b0_10: {sel_y, negate} = 2'b01;   // cos -X
            3'b0_11: {sel_y, negate} = 2'b10;   // cos  Y
            3'b1_00: {sel_y, negate} = 2'b10;   // sin  Y
            3'b1_01: {sel_y, negate} = 2'b00;   // sin  X
            3'b1_10: {sel_y, negate} = 2'b11;   // sin -Y
            default: {sel_y, negate} = 2'b01;   // sin -X
        endcase
    end

    assign mux_sal = sel_y ? y_new : x_new;

    // Held stable until next operation
    always_ff @(posedge clk)
    begin
        if (rst)
            data_output <= '0;
        else if (enab_out)
            data_output <= {mux_sal[DATA_W-1] ^ negate, mux_sal[DATA_W-2:0]};
    end

endmodule : quadrant_fixup

`default_nettype wire

// ==== verilog/exp_shift_stage.sv ====
// CORDIC 2^-i scaling by exponent subtraction, adder operand select and direction
`default_nettype none

module exp_shift_stage import cordic_pkg::*;
#(
    parameter int ITER_BITS = cordic_pkg::ITER_BITS
)
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   enab_rb3,           // Stage register load
    input  wire iter_t  iter_count,         // Shift amount
    input  wire var_t   var_count,
    input  wire float_t x_cur,
    input  wire float_t y_cur,
    input  wire float_t z_cur,
    input  wire float_t atan_value,
    output float_t      add_subt_data_a,
    output float_t      add_subt_data_b,
    output logic        op_add_subt         // 1 = A minus B
);

    logic [EXP_W-1:0] shift_amt;
    float_t x_sh, y_sh;                     // Scaled X and Y
    float_t atan_q;
    logic   z_sign_q;                       // Rotation direction

    // Divide by 2^n, flush to zero once the exponent would underflow
    function automatic float_t scale_down(input float_t v, input logic [EXP_W-1:0] n);
        float_t r;
        if (v[DATA_W-2:MAN_W] <= n)
            r = '0;
        else
            r = {v[DATA_W-1], v[DATA_W-2:MAN_W] - n, v[MAN_W-1:0]};
        return r;
    endfunction

    assign shift_amt = {{(EXP_W-ITER_BITS){1'b0}}, iter_count};

    // ==============================
    // Stage registers
    // ==============================
    always_ff @(posedge clk)
    begin
        if (rst)
            z_sign_q <= 1'b0;
        else if (enab_rb3)
            z_sign_q <= z_cur[DATA_W-1];
    end

    always_ff @(posedge clk)
    begin
        if (enab_rb3)
        begin
            x_sh   <= scale_down(x_cur, shift_amt);
            y_sh   <= scale_down(y_cur, shift_amt);
            atan_q <= atan_value;
        end
    end

    // ==============================
    // Adder operands
    // ==============================
    always_comb
    begin
        case (var_count)
            VAR_X:
            begin
                add_subt_data_a = x_cur;        // x - d*y*2^-i
                add_subt_data_b = y_sh;
                op_add_subt     = ~z_sign_q;
            end
            VAR_Y:
            begin
                add_subt_data_a = y_cur;        // y + d*x*2^-i
                add_subt_data_b = x_sh;
                op_add_subt     = z_sign_q;
            end
            default:
            begin
                add_subt_data_a = z_cur;        // z - d*atan
                add_subt_data_b = atan_q;
                op_add_subt     = ~z_sign_q;
            end
        endcase
    end

endmodule : exp_shift_stage

`default_nettype wire

// ==== verilog/cordic_xyz_regs.sv ====
// CORDIC X/Y/Z register banks for input capture, operands and adder write-back
`default_nettype none

module cordic_xyz_regs import cordic_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   enab_rb1,           // Capture inputs
    input  wire logic   enab_rb2,           // Load operands
    input  wire logic   first_iter,         // Pick initial values
    input  wire var_t   var_count,          // Variable being summed
    input  wire logic   ready_add_subt,
    input  wire float_t data_in,
    input  wire float_t result_add_subt,
    input  wire logic   operation,
    input  wire logic [1:0] shift_region_flag,
    output float_t      x_cur,
    output float_t      y_cur,
    output float_t      z_cur,
    output logic        operation_q,
    output logic [1:0]  region_q,
    output float_t      x_new,
    output float_t      y_new
);

    float_t z_init;                         // Captured angle
    float_t z_new;                          // Z write-back

    // ==============================
    // Input capture
    // ==============================
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            operation_q <= 1'b0;
            region_q    <= 2'b00;
        end
        else if (enab_rb1)
        begin
            operation_q <= operation;
            region_q    <= shift_region_flag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (enab_rb1)
            z_init <= data_in;
    end

    // Operands, initial set on iteration 0
    always_ff @(posedge clk)
    begin
        if (enab_rb2)
        begin
            x_cur <= first_iter ? X_INIT : x_new;
            y_cur <= first_iter ? '0     : y_new;   // Y starts at zero
            z_cur <= first_iter ? z_init : z_new;
        end
    end

    // ==============================
    // Adder write-back
    // ==============================
    always_ff @(posedge clk)
    begin
        if (ready_add_subt)
        begin
            case (var_count)
                VAR_X:   x_new <= result_add_subt;
                VAR_Y:   y_new <= result_add_subt;
                VAR_Z:   z_new <= result_add_subt;
                default: ;                          // No fourth variable
            endcase
        end
    end

endmodule : cordic_xyz_regs

`default_nettype wire

// ==== verilog/cordic_fsm.sv ====
// CORDIC control FSM sequencing capture, iterations, adder handshakes and result hold
`default_nettype none

module cordic_fsm
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic beg_fsm_cordic,   // Start, only seen in idle
    input  wire logic ack_cordic,
    input  wire logic ready_add_subt,   // Adder done pulse
    input  wire logic max_tick_iter,    // Last iteration
    input  wire logic max_tick_var,     // Z written back
    output logic      ready_cordic,
    output logic      beg_add_subt,
    output logic      enab_rb1,         // Input capture
    output logic      enab_rb2,         // Operand load
    output logic      enab_rb3,         // Shift stage load
    output logic      enab_cont_iter,
    output logic      clear_counters,
    output logic      enab_out
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_LOAD,        // Counters cleared
        ST_OPER,        // Operand registers
        ST_SHIFT,       // Scaled X/Y, atan, Z sign
        ST_ADD_ISSUE,   // One beg pulse
        ST_ADD_WAIT,    // Hold until adder answers
        ST_VAR_NEXT,    // Next variable or next iteration
        ST_OUT,         // Register result
        ST_HOLD         // Wait for acknowledge
    } state_t;

    state_t state, state_nxt;

    // ==============================
    // State register
    // ==============================
    always_ff @(posedge clk)
    begin
        if (rst)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    // ==============================
    // Next state
    // ==============================
    always_comb
    begin
        state_nxt = state;                          // Default stay
        case (state)
            ST_IDLE:      if (beg_fsm_cordic) state_nxt = ST_LOAD;
            ST_LOAD:      state_nxt = ST_OPER;
            ST_OPER:      state_nxt = ST_SHIFT;
            ST_SHIFT:     state_nxt = ST_ADD_ISSUE;
            ST_ADD_ISSUE: state_nxt = ST_ADD_WAIT;
            ST_ADD_WAIT:  if (ready_add_subt) state_nxt = ST_VAR_NEXT;
            ST_VAR_NEXT:
            begin
                if (!max_tick_var)
                    state_nxt = ST_ADD_ISSUE;       // Y or Z still pending
                else if (max_tick_iter)
                    state_nxt = ST_OUT;             // All iterations done
                else
                    state_nxt = ST_OPER;
            end
            ST_OUT:       state_nxt = ST_HOLD;
            ST_HOLD:      if (ack_cordic) state_nxt = ST_IDLE;
            default:      state_nxt = ST_IDLE;
        endcase
    end

    // Strobes decoded from state
    assign enab_rb1       = (state == ST_IDLE) && beg_fsm_cordic;   // Capture with start
    assign clear_counters = (state == ST_LOAD);
    assign enab_rb2       = (state == ST_OPER);
    assign enab_rb3       = (state == ST_SHIFT);
    assign beg_add_subt   = (state == ST_ADD_ISSUE);
    assign enab_cont_iter = (state == ST_VAR_NEXT) && max_tick_var && !max_tick_iter;
    assign enab_out       = (state == ST_OUT);
    assign ready_cordic   = (state == ST_HOLD);  // Level until ack

endmodule : cordic_fsm

`default_nettype wire

// ==== verilog/cordic_counters.sv ====
// CORDIC iteration and variable counters with terminal ticks
`default_nettype none

module cordic_counters import cordic_pkg::*;
#(
    parameter int ITER_BITS = cordic_pkg::ITER_BITS
)
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic clear_counters,   // Start of operation
    input  wire logic enab_cont_iter,   // Next iteration
    input  wire logic ready_add_subt,   // One variable done
    output iter_t     iter_count,
    output var_t      var_count,
    output logic      first_iter,
    output logic      max_tick_iter,
    output logic      max_tick_var
);

    // Iteration counter
    always_ff @(posedge clk)
    begin
        if (rst || clear_counters)
            iter_count <= '0;
        else if (enab_cont_iter)
            iter_count <= iter_count + 1'b1;
    end

    // Variable counter, X Y Z then rests at NUM_VARS
    always_ff @(posedge clk)
    begin
        if (rst || clear_counters || enab_cont_iter)
            var_count <= '0;
        else if (ready_add_subt)
            var_count <= var_count + 1'b1;
    end

    assign first_iter    = (iter_count == '0);                          // Use initial values
    assign max_tick_iter = (iter_count == iter_t'((2 ** ITER_BITS) - 1)); // Last pass
    assign max_tick_var  = (var_count == var_t'(NUM_VARS));             // After Z update

endmodule : cordic_counters

`default_nettype wire

// ==== verilog/atan_rom.sv ====
// Single-precision arctangent table, atan(2^-i) per CORDIC iteration
`default_nettype none

module atan_rom import cordic_pkg::*;
#(
    parameter int ITER_BITS = cordic_pkg::ITER_BITS
)
(
    input  wire iter_t iter_count,      // Table index
    output float_t     atan_value
);

    always_comb
    begin
        case (iter_count[ITER_BITS-1:0])
            4'd0:    atan_value = 32'h3f490fdb;    // pi/4
            4'd1:    atan_value = 32'h3eed6338;
            4'd2:    atan_value = 32'h3e7adbb0;
            4'd3:    atan_value = 32'h3dfeadd5;
            4'd4:    atan_value = 32'h3d7faade;
            4'd5:    atan_value = 32'h3cffeaae;
            4'd6:    atan_value = 32'h3c7ffaab;
            4'd7:    atan_value = 32'h3bfffeab;
            4'd8:    atan_value = 32'h3b7fffab;
            4'd9:    atan_value = 32'h3affffeb;
            4'd10:   atan_value = 32'h3a7ffffb;
            4'd11:   atan_value = 32'h39ffffff;
            4'd12:   atan_value = 32'h39800000;    // atan equals 2^-i from here
            4'd13:   atan_value = 32'h39000000;
            4'd14:   atan_value = 32'h38800000;
            4'd15:   atan_value = 32'h38000000;
            default: atan_value = '0;
        endcase
    end

endmodule : atan_rom

`default_nettype wire

// ==== verilog/cordic_pkg.sv ====
// CORDIC sine/cosine shared widths, iteration constants and types
`default_nettype none

package cordic_pkg;

    // ==============================
    // Float format
    // ==============================
    localparam int DATA_W = 32;                 // Single precision word
    localparam int EXP_W  = 8;                  // Exponent field
    localparam int MAN_W  = 23;                 // Mantissa field

    // ==============================
    // Iteration control
    // ==============================
    localparam int ITER_BITS = 4;               // 16 iterations
    localparam int NUM_VARS  = 3;               // X, Y, Z per iteration

    localparam logic [1:0] VAR_X = 2'd0;        // Variable counter codes
    localparam logic [1:0] VAR_Y = 2'd1;
    localparam logic [1:0] VAR_Z = 2'd2;

    // Gain compensation for 16 iterations, 0.607252935
    localparam logic [DATA_W-1:0] X_INIT = 32'h3f1b74ee;

    typedef logic [DATA_W-1:0]    float_t;      // Raw IEEE single bits
    typedef logic [ITER_BITS-1:0] iter_t;       // Iteration index
    typedef logic [1:0]           var_t;        // Variable index

endpackage : cordic_pkg

`default_nettype wire
